// File: macplus_glue.f
hdl/macplus_pkg.sv
hdl/clock_enables.sv
hdl/reset_sequencer.sv
hdl/rom_loader.sv
hdl/disk_image_tracker.sv
hdl/sdram_port_mux.sv
hdl/turbo_control.sv
hdl/macplus_glue.sv
test/tb_clock_gen.sv
test/tb_macplus_glue.sv

// File: Bender.yml
package:
  name: macplus_glue

sources:
  - hdl/macplus_pkg.sv
  - hdl/clock_enables.sv
  - hdl/reset_sequencer.sv
  - hdl/rom_loader.sv
  - hdl/disk_image_tracker.sv
  - hdl/sdram_port_mux.sv
  - hdl/turbo_control.sv
  - hdl/macplus_glue.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_macplus_glue.sv

// File: test/tb_macplus_glue.sv
//========================================
// testbench for the glue top level
// stimulus, reference rules, assertions
// for enables, reset, loader, disks,
// turbo, led, screen decode and aspect
//========================================

`timescale 1ns/1ps

module tb_macplus_glue;

	localparam int RESET_HOLD    = 5;
	localparam int ACTIVITY_HOLD = 20;
	localparam int BOOT_ACKS     = 3;

	logic                    clk_sys;
	logic                    n_reset;
	macplus_pkg::host_load_t host;
	logic                    dio_slot;
	macplus_pkg::chip_mem_t  chip;
	macplus_pkg::word_t      sdram_dout;
	logic [1:0]              disk_read_ack;
	logic [1:0]              disk_eject;
	logic [1:0]              disk_motor;
	logic [1:0]              disk_access;
	logic                    sd_ack;
	logic                    cpu_reset_out_n;
	logic                    reset_request;
	logic [1:0]              mem_option;
	logic                    turbo_request;
	logic                    aspect_wide;
	macplus_pkg::ce_t        ce;
	logic                    sys_reset_n;
	macplus_pkg::ram_size_t  ram_size;
	logic                    load_wait;
	macplus_pkg::sdram_req_t sdram;
	macplus_pkg::word_t      chip_rdata;
	logic [1:0]              screen_write;
	logic [1:0]              disk_inserted;
	logic [1:0]              disk_double_sided;
	logic                    led_user;
	logic                    turbo;
	logic [7:0]              arx;
	logic [7:0]              ary;

	int check_count   = 0;
	int error_count   = 0;
	int timeout_count = 0;

	tb_clock_gen #(
		.PERIOD_NS    (100),
		.RESET_CYCLES (4)
	) u_clock_gen (
		.clk_sys (clk_sys),
		.n_reset (n_reset)
	);

	macplus_glue #(
		.RESET_HOLD    (RESET_HOLD),
		.ACTIVITY_HOLD (ACTIVITY_HOLD),
		.BOOT_ACKS     (BOOT_ACKS)
	) UUT (
		.clk_sys           (clk_sys),
		.n_reset           (n_reset),
		.host              (host),
		.dio_slot          (dio_slot),
		.chip              (chip),
		.sdram_dout        (sdram_dout),
		.disk_read_ack     (disk_read_ack),
		.disk_eject        (disk_eject),
		.disk_motor        (disk_motor),
		.disk_access       (disk_access),
		.sd_ack            (sd_ack),
		.cpu_reset_out_n   (cpu_reset_out_n),
		.reset_request     (reset_request),
		.mem_option        (mem_option),
		.turbo_request     (turbo_request),
		.aspect_wide       (aspect_wide),
		.ce                (ce),
		.sys_reset_n       (sys_reset_n),
		.ram_size          (ram_size),
		.load_wait         (load_wait),
		.sdram             (sdram),
		.chip_rdata        (chip_rdata),
		.screen_write      (screen_write),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided),
		.led_user          (led_user),
		.turbo             (turbo),
		.arx               (arx),
		.ary               (ary)
	);

	// ========================================
	// concurrent checks
	// ========================================

	// enables are cleared by the board reset
	assert property (@(posedge clk_sys) !n_reset |=> ce == '0)
		else begin
			error_count++;
			$display("CHECK FAILED ce reset: expected 0, actual %b", $sampled(ce));
		end

	// 8-cycle slot, mid at +4, late at +7, pixel every 4
	assert property (@(posedge clk_sys) disable iff (!n_reset) ce.ce_cpu |-> ##8 ce.ce_cpu)
		else begin
			error_count++;
			$display("CHECK FAILED ce_cpu period: expected 1, actual %b", $sampled(ce.ce_cpu));
		end
	assert property (@(posedge clk_sys) disable iff (!n_reset) ce.ce_cpu |-> ##4 ce.ce_mid)
		else begin
			error_count++;
			$display("CHECK FAILED ce_mid phase: expected 1, actual %b", $sampled(ce.ce_mid));
		end
	assert property (@(posedge clk_sys) disable iff (!n_reset) ce.ce_cpu |-> ##7 ce.ce_late)
		else begin
			error_count++;
			$display("CHECK FAILED ce_late phase: expected 1, actual %b",
				$sampled(ce.ce_late));
		end
	assert property (@(posedge clk_sys) disable iff (!n_reset) ce.ce_pix |-> ##4 ce.ce_pix)
		else begin
			error_count++;
			$display("CHECK FAILED ce_pix period: expected 1, actual %b", $sampled(ce.ce_pix));
		end

	// any reset source holds the system down
	assert property (@(posedge clk_sys)
		(!n_reset || reset_request || !cpu_reset_out_n) |=> !sys_reset_n)
		else begin
			error_count++;
			$display("CHECK FAILED reset source: expected 0, actual %b", $sampled(sys_reset_n));
		end

	// ram size only moves across a reset
	assert property (@(posedge clk_sys) disable iff (!n_reset) sys_reset_n |=> $stable(ram_size))
		else begin
			error_count++;
			$display("CHECK FAILED ram size stable: expected %0d, actual %0d",
				$past(ram_size), $sampled(ram_size));
		end

	// wait clears one cycle after a slot has ended
	assert property (@(posedge clk_sys) disable iff (!n_reset)
		$fell(load_wait) |-> !$past(dio_slot) && $past(dio_slot, 2))
		else begin
			error_count++;
			$display("CHECK FAILED load_wait release: expected slot end, actual dio_slot %b",
				$past(dio_slot));
		end

	assert property (@(posedge clk_sys) !sys_reset_n |=> !turbo)
		else begin
			error_count++;
			$display("CHECK FAILED turbo reset: expected 0, actual %b", $sampled(turbo));
		end

	// 16:9 or 4:3
	assert property (@(posedge clk_sys) aspect_wide |-> arx == 8'd16 && ary == 8'd9)
		else begin
			error_count++;
			$display("CHECK FAILED aspect wide: expected 16:9, actual %0d:%0d", arx, ary);
		end
	assert property (@(posedge clk_sys) !aspect_wide |-> arx == 8'd4 && ary == 8'd3)
		else begin
			error_count++;
			$display("CHECK FAILED aspect normal: expected 4:3, actual %0d:%0d", arx, ary);
		end

	// ========================================
	// helpers
	// ========================================

	// inputs change 1 ns after the edge, outputs are read there too
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeout_count++;
		$display("TIMEOUT: %s", what);
	endtask

	// word offset of each image in the load area
	function automatic int unsigned image_base(input logic [7:0] idx);
		int unsigned base;
		case (idx)
			8'd0:    base = 0;
			8'd1:    base = macplus_pkg::INT_DISK_OFFSET;
			default: base = macplus_pkg::EXT_DISK_OFFSET;
		endcase
		return base;
	endfunction

	// disk bytes show up on both halves
	function automatic logic [15:0] dup_byte(input logic [15:0] w, input logic odd);
		logic [7:0] b;
		b = odd ? w[7:0] : w[15:8];
		return {b, b};
	endfunction

	// screen buffer is the top 32 KB of the configured ram
	task automatic check_screen(input macplus_pkg::ram_size_t size);
		int                     top;
		macplus_pkg::mem_addr_t a;
		case (size)
			2'd0:    top = 16;
			2'd1:    top = 18;
			2'd2:    top = 19;
			default: top = 21;
		endcase
		a = macplus_pkg::mem_addr_t'($urandom);
		for (int b = 15; b <= top; b++) begin
			a[b] = 1'b1;
		end
		chip = '0;
		chip.addr = a;
		chip.ram_we = 1'b1;
		chip.uds = 1'b1;
		next_cycle();
		check_equal("screen upper", 32'b10, screen_write);
		chip.uds = 1'b0;
		chip.lds = 1'b1;
		next_cycle();
		check_equal("screen lower", 32'b01, screen_write);
		// one bit under the buffer
		chip.addr[top] = 1'b0;
		next_cycle();
		check_equal("screen miss", 0, screen_write);
		chip.addr[top] = 1'b1;
		chip.ram_we = 1'b0;
		next_cycle();
		check_equal("screen read", 0, screen_write);
		chip = '0;
	endtask

	// drops the reset sources and counts ce_mid until the system comes up
	task automatic release_and_count();
		int                     n;
		int                     mids;
		macplus_pkg::ram_size_t exp_size;
		n = 0;
		mids = 0;
		exp_size = mem_option + 2'd1;
		reset_request = 1'b0;
		cpu_reset_out_n = 1'b1;
		while (!sys_reset_n && n < 200) begin
			if (ce.ce_mid) begin
				mids++;
			end
			next_cycle();
			n++;
		end
		if (!sys_reset_n) begin
			report_timeout("sys_reset_n never rose after the reset sources cleared");
		end
		check_equal("reset hold", RESET_HOLD, mids);
		check_equal("ram size", exp_size, ram_size);
		check_screen(exp_size);
	endtask

	// one byte pair, then a bus slot for the packed word
	task automatic send_word(input int unsigned word);
		logic [7:0]  hi;
		logic [7:0]  lo;
		logic [31:0] exp_addr;
		int          n;
		hi = 8'($urandom);
		lo = 8'($urandom);
		exp_addr = 32'h200000 + image_base(host.index) + word;
		n = 0;
		// back-pressure from the loader
		while (load_wait && n < 50) begin
			next_cycle();
			n++;
		end
		if (load_wait) begin
			report_timeout("load_wait stayed high before a host strobe");
		end
		host.write = 1'b1;
		host.addr = 25'(word * 2);
		host.data = hi;
		next_cycle();
		host.addr = 25'(word * 2 + 1);
		host.data = lo;
		next_cycle();
		host.write = 1'b0;
		n = 0;
		while (!load_wait && n < 10) begin
			next_cycle();
			n++;
		end
		if (!load_wait) begin
			report_timeout("load_wait did not rise after a completed word");
		end
		// write level follows the wait level outside the slot
		next_cycle();
		dio_slot = 1'b1;
		next_cycle();
		check_equal("load we", 1, sdram.we);
		check_equal("load strobes", 32'b11, sdram.ds);
		check_equal("load data", {hi, lo}, sdram.din);
		check_equal("load addr", exp_addr, sdram.addr);
		check_equal("load rdata", 32'hffff, chip_rdata);
		next_cycle();
		dio_slot = 1'b0;
		n = 0;
		while (load_wait && n < 10) begin
			next_cycle();
			n++;
		end
		check_equal("load wait clear", 0, load_wait);
	endtask

	task automatic pulse_ack();
		sd_ack = 1'b1;
		next_cycle();
		sd_ack = 1'b0;
		next_cycle();
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial begin : stimulus
		int          n;
		logic [15:0] dout;
		void'($urandom(34592));
		host = '0;
		dio_slot = 1'b0;
		chip = '0;
		sdram_dout = '0;
		disk_read_ack = '0;
		disk_eject = '0;
		disk_motor = '0;
		disk_access = '0;
		sd_ack = 1'b0;
		cpu_reset_out_n = 1'b1;
		reset_request = 1'b1;
		mem_option = 2'd1;
		turbo_request = 1'b1;
		aspect_wide = 1'b0;

		n = 0;
		while (!n_reset && n < 20) begin
			next_cycle();
			n++;
		end
		if (!n_reset) begin
			report_timeout("board reset never released");
		end

		// menu reset overlapped by the cpu reset line
		next_cycle();
		next_cycle();
		cpu_reset_out_n = 1'b0;
		next_cycle();
		check_equal("reset held", 0, sys_reset_n);
		release_and_count();

		// rom, internal and external images
		for (int idx = 0; idx < 3; idx++) begin
			host.index = 8'(idx);
			host.active = 1'b1;
			for (int k = 0; k < 3; k++) begin
				send_word($urandom_range(4095));
			end
			host.active = 1'b0;
			next_cycle();
			check_equal("short image", 0, disk_inserted);
		end

		// full size images end the download
		aspect_wide = 1'b1;
		host.index = 8'd1;
		host.active = 1'b1;
		host.addr = 25'(macplus_pkg::DS_IMAGE_WORDS * 2);
		next_cycle();
		host.active = 1'b0;
		next_cycle();
		check_equal("ds inserted", 32'b01, disk_inserted);
		check_equal("ds sided", 32'b01, disk_double_sided);
		host.index = 8'd2;
		host.active = 1'b1;
		host.addr = 25'(macplus_pkg::SS_IMAGE_WORDS * 2);
		next_cycle();
		host.active = 1'b0;
		next_cycle();
		check_equal("ss inserted", 32'b11, disk_inserted);
		check_equal("ss sided", 32'b01, disk_double_sided);
		disk_eject = 2'b01;
		next_cycle();
		disk_eject = 2'b00;
		check_equal("eject int", 32'b10, disk_inserted);
		check_equal("eject int sided", 0, disk_double_sided);
		disk_eject = 2'b10;
		next_cycle();
		disk_eject = 2'b00;
		check_equal("eject ext", 0, disk_inserted);
		host = '0;

		// disk reads, then plain and rom reads
		for (int k = 0; k < 4; k++) begin
			dout = 16'($urandom);
			sdram_dout = dout;
			chip.addr = macplus_pkg::mem_addr_t'($urandom);
			disk_read_ack = k[0] ? 2'b10 : 2'b01;
			next_cycle();
			check_equal("disk read", dup_byte(dout, chip.addr[0]), chip_rdata);
		end
		disk_read_ack = 2'b00;
		next_cycle();
		check_equal("plain read", sdram_dout, chip_rdata);
		// top address bit low, so only the rom select can raise word bit 20
		chip.addr[21] = 1'b0;
		chip.rom_oe = 1'b1;
		next_cycle();
		check_equal("rom addr", (32'(chip.addr) >> 1) | 32'h100000, sdram.addr);
		check_equal("rom oe", 1, sdram.oe);
		chip = '0;

		// led with motor on: dark while the access timer runs
		check_equal("led idle", 0, led_user);
		disk_motor = 2'b01;
		next_cycle();
		check_equal("led motor", 1, led_user);
		disk_access = 2'b01;
		next_cycle();
		disk_access = 2'b00;
		n = 1;
		while (led_user && n < 10) begin
			next_cycle();
			n++;
		end
		check_equal("led access", 0, led_user);
		while (!led_user && n < ACTIVITY_HOLD + 10) begin
			next_cycle();
			n++;
		end
		check_count++;
		assert (n >= ACTIVITY_HOLD && n <= ACTIVITY_HOLD + 3) else begin
			error_count++;
			$display("CHECK FAILED led hold: expected %0d to %0d cycles, actual %0d",
				ACTIVITY_HOLD, ACTIVITY_HOLD + 3, n);
		end
		disk_motor = 2'b00;
		next_cycle();
		check_equal("led off", 0, led_user);
		host.active = 1'b1;
		next_cycle();
		check_equal("led download", 1, led_user);
		host.active = 1'b0;

		// cpu reset instruction, bigger ram
		mem_option = 2'd2;
		cpu_reset_out_n = 1'b0;
		next_cycle();
		check_equal("cpu reset drop", 0, sys_reset_n);
		next_cycle();
		release_and_count();

		// turbo waits for the boot acks and a slot
		aspect_wide = 1'b0;
		pulse_ack();
		pulse_ack();
		dio_slot = 1'b1;
		next_cycle();
		dio_slot = 1'b0;
		next_cycle();
		check_equal("turbo early", 0, turbo);
		pulse_ack();
		check_equal("turbo no slot", 0, turbo);
		dio_slot = 1'b1;
		n = 0;
		while (!turbo && n < 10) begin
			next_cycle();
			n++;
		end
		check_equal("turbo on", 1, turbo);
		turbo_request = 1'b0;
		next_cycle();
		next_cycle();
		dio_slot = 1'b0;
		check_equal("turbo follows", 0, turbo);

		// motor cuts the boot delay short, ram size code wraps to 128 KB
		turbo_request = 1'b1;
		mem_option = 2'd3;
		cpu_reset_out_n = 1'b0;
		next_cycle();
		next_cycle();
		release_and_count();
		check_equal("turbo after reset", 0, turbo);
		disk_motor = 2'b10;
		next_cycle();
		disk_motor = 2'b00;
		dio_slot = 1'b1;
		n = 0;
		while (!turbo && n < 10) begin
			next_cycle();
			n++;
		end
		dio_slot = 1'b0;
		check_equal("turbo motor", 1, turbo);
		next_cycle();

		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: test/tb_clock_gen.sv
//========================================
// testbench clock and reset generator
//========================================

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic n_reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// board reset, released just after an edge
	initial begin
		n_reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 n_reset = 1'b1;
	end

endmodule

// File: hdl/macplus_glue.sv
//========================================
// glue logic top level
// aspect select and block instances
//========================================

`timescale 1ns/1ps

module macplus_glue #(
	parameter int RESET_HOLD    = 65535,
	parameter int ACTIVITY_HOLD = 1000000,
	parameter int BOOT_ACKS     = 20
) (
	input  logic                    clk_sys,
	input  logic                    n_reset,
	// host download and chipset side
	input  macplus_pkg::host_load_t host,
	input  logic                    dio_slot,
	input  macplus_pkg::chip_mem_t  chip,
	input  macplus_pkg::word_t      sdram_dout,
	input  logic [1:0]              disk_read_ack,
	input  logic [1:0]              disk_eject,
	input  logic [1:0]              disk_motor,
	input  logic [1:0]              disk_access,
	input  logic                    sd_ack,
	input  logic                    cpu_reset_out_n,
	// status options
	input  logic                    reset_request,
	input  logic [1:0]              mem_option,
	input  logic                    turbo_request,
	input  logic                    aspect_wide,
	// outputs
	output macplus_pkg::ce_t        ce,
	output logic                    sys_reset_n,
	output macplus_pkg::ram_size_t  ram_size,
	output logic                    load_wait,
	output macplus_pkg::sdram_req_t sdram,
	output macplus_pkg::word_t      chip_rdata,
	output logic [1:0]              screen_write,
	output logic [1:0]              disk_inserted,
	output logic [1:0]              disk_double_sided,
	output logic                    led_user,
	output logic                    turbo,
	output logic [7:0]              arx,
	output logic [7:0]              ary
);

	macplus_pkg::word_t      load_word;
	macplus_pkg::word_addr_t load_addr;
	logic                    load_write;

	// 16:9 or 4:3 for the scaler
	assign arx = aspect_wide ? 8'd16 : 8'd4;
	assign ary = aspect_wide ? 8'd9 : 8'd3;

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.n_reset (n_reset),
		.ce      (ce)
	);

	reset_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) u_reset_sequencer (
		.clk_sys         (clk_sys),
		.n_reset         (n_reset),
		.ce              (ce),
		.reset_request   (reset_request),
		.cpu_reset_out_n (cpu_reset_out_n),
		.mem_option      (mem_option),
		.sys_reset_n     (sys_reset_n),
		.ram_size        (ram_size)
	);

	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.n_reset    (n_reset),
		.host       (host),
		.dio_slot   (dio_slot),
		.load_word  (load_word),
		.load_addr  (load_addr),
		.load_write (load_write),
		.load_wait  (load_wait)
	);

	disk_image_tracker #(
		.ACTIVITY_HOLD (ACTIVITY_HOLD)
	) u_disk_image_tracker (
		.clk_sys           (clk_sys),
		.n_reset           (n_reset),
		.host              (host),
		.disk_eject        (disk_eject),
		.disk_motor        (disk_motor),
		.disk_access       (disk_access),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided),
		.led_user          (led_user)
	);

	sdram_port_mux u_sdram_port_mux (
		.download      (host.active),
		.dio_slot      (dio_slot),
		.ram_size      (ram_size),
		.load_word     (load_word),
		.load_addr     (load_addr),
		.load_write    (load_write),
		.chip          (chip),
		.sdram_dout    (sdram_dout),
		.disk_read_ack (disk_read_ack),
		.sdram         (sdram),
		.chip_rdata    (chip_rdata),
		.screen_write  (screen_write)
	);

	turbo_control #(
		.BOOT_ACKS (BOOT_ACKS)
	) u_turbo_control (
		.clk_sys       (clk_sys),
		.sys_reset_n   (sys_reset_n),
		.turbo_request (turbo_request),
		.sd_ack        (sd_ack),
		.disk_motor    (disk_motor),
		.dio_slot      (dio_slot),
		.turbo         (turbo)
	);

endmodule

// File: hdl/turbo_control.sv
//========================================
// delayed turbo switch
// waits out the boot disk accesses
//========================================

`timescale 1ns/1ps

module turbo_control #(
	parameter int BOOT_ACKS = 20
) (
	input  logic       clk_sys,
	input  logic       sys_reset_n,
	input  logic       turbo_request,
	input  logic       sd_ack,
	input  logic [1:0] disk_motor,
	input  logic       dio_slot,
	output logic       turbo
);

	localparam int CW = $clog2(BOOT_ACKS + 1);

	logic          ack_q;
	logic [CW-1:0] ack_cnt;

	// scsi boot fails with turbo on, so hold it off for a few transfers
	always_ff @(posedge clk_sys) begin
		if (!sys_reset_n) begin
			ack_q   <= 1'b0;
			ack_cnt <= CW'(BOOT_ACKS);
			turbo   <= 1'b0;
		end else begin
			ack_q <= sd_ack;
			// count falling edges of the block ack
			if (ack_q && !sd_ack && ack_cnt != '0) begin
				ack_cnt <= ack_cnt - 1'b1;
			end
			// floppy boot, no need to wait
			if (|disk_motor) begin
				ack_cnt <= '0;
			end
			// switch only at a slot boundary
			if (ack_cnt == '0 && dio_slot) begin
				turbo <= turbo_request;
			end
		end
	end

endmodule

// File: hdl/sdram_port_mux.sv
//========================================
// sdram request mux, disk read byte
// duplication and screen write decode
//========================================

`timescale 1ns/1ps

module sdram_port_mux (
	input  logic                    download,
	input  logic                    dio_slot,
	input  macplus_pkg::ram_size_t  ram_size,
	input  macplus_pkg::word_t      load_word,
	input  macplus_pkg::word_addr_t load_addr,
	input  logic                    load_write,
	input  macplus_pkg::chip_mem_t  chip,
	input  macplus_pkg::word_t      sdram_dout,
	input  logic [1:0]              disk_read_ack,
	output macplus_pkg::sdram_req_t sdram,
	output macplus_pkg::word_t      chip_rdata,
	output logic [1:0]              screen_write
);

	logic               load_cycle;
	macplus_pkg::word_t byte_dup;
	logic               screen_hit;

	// loader owns the bus only inside its slot
	assign load_cycle = download && dio_slot;

	always_comb begin
		if (load_cycle) begin
			// load area starts at word 0x200000
			sdram.addr = {4'b0001, load_addr};
			sdram.din  = load_word;
			sdram.ds   = 2'b11;
			sdram.we   = load_write;
			sdram.oe   = 1'b0;
		end else begin
			// rom window at word 0x100000
			sdram.addr = {4'b0000, chip.addr[21] | chip.rom_oe, chip.addr[20:1]};
			sdram.din  = chip.din;
			sdram.ds   = {chip.uds, chip.lds};
			sdram.we   = chip.ram_we;
			sdram.oe   = chip.ram_oe || chip.rom_oe;
		end
	end

	// disk images are byte wide, odd address picks the low byte
	assign byte_dup = chip.addr[0] ? {sdram_dout[7:0], sdram_dout[7:0]}
	                               : {sdram_dout[15:8], sdram_dout[15:8]};

	always_comb begin
		if (load_cycle) begin
			chip_rdata = 16'hffff;
		end else if (|disk_read_ack) begin
			chip_rdata = byte_dup;
		end else begin
			chip_rdata = sdram_dout;
		end
	end

	// screen buffer sits in the top 32 KB of the configured ram
	always_comb begin
		case (ram_size)
			2'd0:    screen_hit = &chip.addr[16:15];
			2'd1:    screen_hit = &chip.addr[18:15];
			2'd2:    screen_hit = &chip.addr[19:15];
			default: screen_hit = &chip.addr[21:15];
		endcase
	end

	assign screen_write = {chip.uds, chip.lds} & {2{chip.ram_we && screen_hit}};

endmodule

// File: hdl/disk_image_tracker.sv
//========================================
// floppy image size flags per drive,
// eject clearing and activity led
//========================================

`timescale 1ns/1ps

module disk_image_tracker #(
	parameter int ACTIVITY_HOLD = 1000000
) (
	input  logic                    clk_sys,
	input  logic                    n_reset,
	input  macplus_pkg::host_load_t host,
	input  logic [1:0]              disk_eject,
	input  logic [1:0]              disk_motor,
	input  logic [1:0]              disk_access,
	output logic [1:0]              disk_inserted,
	output logic [1:0]              disk_double_sided,
	output logic                    led_user
);

	localparam int TW = $clog2(ACTIVITY_HOLD + 1);

	logic          active_q;
	logic [1:0]    ds_flag;
	logic [1:0]    ss_flag;
	logic [23:0]   final_words;
	logic [TW-1:0] act_timer;
	logic          act_on;

	// host counts bytes, images are sized in words
	assign final_words = host.addr[24:1];

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			active_q <= 1'b0;
			ds_flag  <= '0;
			ss_flag  <= '0;
		end else begin
			active_q <= host.active;
			for (int i = 0; i < 2; i++) begin
				// end of a download for this drive
				if (active_q && !host.active && host.index == 8'(i + 1)) begin
					ds_flag[i] <= (final_words == 24'(macplus_pkg::DS_IMAGE_WORDS));
					ss_flag[i] <= (final_words == 24'(macplus_pkg::SS_IMAGE_WORDS));
				end
				// eject from the os wins
				if (disk_eject[i]) begin
					ds_flag[i] <= 1'b0;
					ss_flag[i] <= 1'b0;
				end
			end
		end
	end

	// unknown sizes leave both flags low, drive reads as empty
	assign disk_inserted     = ds_flag | ss_flag;
	assign disk_double_sided = ds_flag;

	// =======================================
	// activity led
	// =======================================

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			act_timer <= '0;
			act_on    <= 1'b0;
		end else begin
			act_on <= (act_timer != '0);
			if (act_timer != '0) begin
				act_timer <= act_timer - 1'b1;
			end
			// retrigger on any access
			if (|disk_access) begin
				act_timer <= TW'(ACTIVITY_HOLD);
			end
		end
	end

	// flickers when access and motor disagree
	assign led_user = host.active || (act_on ^ |disk_motor);

endmodule

// File: hdl/rom_loader.sv
//========================================
// rom and disk image loader
// byte pairing, image placement and
// wait level back to the host
//========================================

`timescale 1ns/1ps

module rom_loader (
	input  logic                    clk_sys,
	input  logic                    n_reset,
	input  macplus_pkg::host_load_t host,
	input  logic                    dio_slot,
	output macplus_pkg::word_t      load_word,
	output macplus_pkg::word_addr_t load_addr,
	output logic                    load_write,
	output logic                    load_wait
);

	logic                    word_done;
	logic                    slot_q;
	logic [7:0]              hi_byte;
	macplus_pkg::word_addr_t image_offset;

	// image base by download index, rom sits at zero
	always_comb begin
		case (host.index)
			8'd0:    image_offset = '0;
			8'd1:    image_offset = macplus_pkg::INT_DISK_OFFSET;
			default: image_offset = macplus_pkg::EXT_DISK_OFFSET;
		endcase
	end

	// =======================================
	// byte pairing
	// =======================================

	// even byte is the upper half (big endian)
	always_ff @(posedge clk_sys) begin
		if (host.write && !host.addr[0]) begin
			hi_byte <= host.data;
		end
		if (host.write && host.addr[0]) begin
			load_word <= {hi_byte, host.data};
			load_addr <= image_offset + host.addr[21:1];
		end
	end

	// one cycle pulse per completed word
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			word_done <= 1'b0;
		end else begin
			word_done <= host.write && host.addr[0];
		end
	end

	// =======================================
	// wait and write levels
	// =======================================

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			slot_q     <= 1'b0;
			load_wait  <= 1'b0;
			load_write <= 1'b0;
		end else begin
			slot_q <= dio_slot;
			// new word pending, hold the host off
			if (word_done) begin
				load_wait <= 1'b1;
			end
			// write level only changes outside the slot
			if (!dio_slot) begin
				load_write <= load_wait;
			end
			// slot ended with the write presented, word is in memory
			if (slot_q && !dio_slot && load_write) begin
				load_wait <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/reset_sequencer.sv
//========================================
// system reset sequencer
// merges reset sources, holds reset for
// a ce_mid count and latches ram size
//========================================

`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_HOLD = 65535
) (
	input  logic                   clk_sys,
	input  logic                   n_reset,
	input  macplus_pkg::ce_t       ce,
	input  logic                   reset_request,
	input  logic                   cpu_reset_out_n,
	input  logic [1:0]             mem_option,
	output logic                   sys_reset_n,
	output macplus_pkg::ram_size_t ram_size
);

	localparam int CW = $clog2(RESET_HOLD + 1);

	logic [CW-1:0] hold_cnt;
	logic          any_source;

	// board reset, menu reset or the cpu's own reset instruction
	assign any_source = !n_reset || reset_request || !cpu_reset_out_n;

	always_ff @(posedge clk_sys) begin
		if (any_source) begin
			hold_cnt    <= CW'(RESET_HOLD);
			sys_reset_n <= 1'b0;
		end else if (hold_cnt != '0) begin
			if (ce.ce_mid) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end else begin
			sys_reset_n <= 1'b1;
		end
	end

	// size code only moves while the system is held in reset
	// option 0 maps to 512 KB, option 3 wraps round to the 128 KB code
	always_ff @(posedge clk_sys) begin
		if (!any_source && hold_cnt != '0) begin
			ram_size <= mem_option + 2'd1;
		end
	end

endmodule

// File: hdl/clock_enables.sv
//========================================
// clock enable divider
// cpu phases 0, 4, 7 and pixel enable
//========================================

`timescale 1ns/1ps

module clock_enables (
	input  logic               clk_sys,
	input  logic               n_reset,
	output macplus_pkg::ce_t   ce
);

	// free running phase of the bus slot
	logic [2:0] phase;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			phase <= '0;
			ce    <= '0;
		end else begin
			phase <= phase + 3'd1;
			// decodes are registered, so each enable lags the phase by one
			ce.ce_cpu  <= (phase == 3'd0);
			ce.ce_mid  <= (phase == 3'd4);
			ce.ce_late <= (phase == 3'd7);
			// every fourth cycle
			ce.ce_pix  <= (phase[1:0] == 2'd0);
		end
	end

endmodule

// File: hdl/macplus_pkg.sv
//========================================
// shared types for the glue logic
// widths, load offsets, image sizes
// and the bus structs between blocks
//========================================

package macplus_pkg;

	// plain vector types
	typedef logic [15:0] word_t;
	typedef logic [20:0] word_addr_t;
	typedef logic [24:0] sdram_addr_t;
	typedef logic [21:0] mem_addr_t;
	// 0 = 128 KB, 1 = 512 KB, 2 = 1 MB, 3 = 4 MB
	typedef logic [1:0]  ram_size_t;
	// 0 = rom, 1 = internal floppy, 2 = external floppy
	typedef logic [7:0]  load_index_t;

	// disk images live after the rom, in words
	localparam word_addr_t INT_DISK_OFFSET = 21'h080000;
	localparam word_addr_t EXT_DISK_OFFSET = 21'h100000;

	// accepted floppy image sizes, in words
	localparam int unsigned DS_IMAGE_WORDS = 409600;
	localparam int unsigned SS_IMAGE_WORDS = 204800;

	// host download bus, one byte per strobe
	typedef struct packed {
		logic        write;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        active;
		load_index_t index;
	} host_load_t;

	// clock enables, one per phase of the 8-cycle bus slot
	typedef struct packed {
		logic ce_cpu;
		logic ce_mid;
		logic ce_late;
		logic ce_pix;
	} ce_t;

	// chipset memory request, all strobes active high
	typedef struct packed {
		mem_addr_t addr;
		word_t     din;
		logic      uds;
		logic      lds;
		logic      ram_we;
		logic      ram_oe;
		logic      rom_oe;
	} chip_mem_t;

	// request toward the sdram controller
	typedef struct packed {
		sdram_addr_t addr;
		word_t       din;
		logic [1:0]  ds;
		logic        we;
		logic        oe;
	} sdram_req_t;

endpackage
